//--- src/xgphy_cfg_pkg.sv
// Configuration defaults: lane count, step counter width, synchronizer depth
package xgphy_cfg_pkg;

	//////////////////////////////
	// Lane configuration
	//////////////////////////////

	// Number of serial lanes sharing one PLL
	parameter int NDEV_DEF = 1;

	//////////////////////////////
	// Reset sequencing
	//////////////////////////////

	// Width of the per-lane step down-counter
	// One reset step lasts 2**SEQ_CNT_W_DEF transceiver clock cycles
	parameter int SEQ_CNT_W_DEF = 7;

	//////////////////////////////
	// Clock domain crossing
	//////////////////////////////

	// Flops in each reset synchronizer chain
	// Two-flop pipe plus one output flop
	parameter int SYNC_STAGES_DEF = 3;

endpackage

//--- src/xgphy_rst_pkg.sv
// Transmit reset stage enumeration and the stage advance function
package xgphy_rst_pkg;

	//////////////////////////////
	// Transmit reset stages
	//////////////////////////////

	// Stages in release order
	// TX_RST_GTX holds everything, TX_RST_DONE means user ready
	typedef enum logic [1:0] {
		TX_RST_GTX  = 2'd0,
		TX_RST_PMA  = 2'd1,
		TX_RST_PCS  = 2'd2,
		TX_RST_DONE = 2'd3
	} tx_rst_stage_t;

	// Stage following the given one
	// Final stage is sticky until the sequencer is reset again
	function automatic tx_rst_stage_t next_stage(input tx_rst_stage_t stage);
		tx_rst_stage_t nxt;
		case (stage)
			TX_RST_GTX:  nxt = TX_RST_PMA;
			TX_RST_PMA:  nxt = TX_RST_PCS;
			TX_RST_PCS:  nxt = TX_RST_DONE;
			TX_RST_DONE: nxt = TX_RST_DONE;
			default:     nxt = TX_RST_GTX;
		endcase
		return nxt;
	endfunction

endpackage

//--- src/xgphy_reset_sync.sv
// Reset synchronizer with asynchronous assertion and synchronous release
`timescale 1ns/1ps

module xgphy_reset_sync #(
	parameter int STAGES = xgphy_cfg_pkg::SYNC_STAGES_DEF
) (
	// Destination clock
	input  logic i_clk,
	// Active high, asynchronous
	input  logic i_arst,
	// Synchronized reset, active high
	output logic o_rst
);

	// Shift chain, bit 0 is the input end
	logic [STAGES-1:0] sync_q;

	//////////////////////////////
	// Shift chain
	//////////////////////////////

	// Fill with ones at once on i_arst
	// Zeros walk in from bit 0 once i_arst clears
	always_ff @(posedge i_clk or posedge i_arst)
	begin
		if (i_arst)
		begin
			sync_q <= '1;
		end
		else
		begin
			sync_q[0] <= 1'b0;
			for (int k = 1; k < STAGES; k++)
			begin
				sync_q[k] <= sync_q[k-1];
			end
		end
	end

	// Last flop is the output
	// Release comes STAGES edges after i_arst falls
	assign o_rst = sync_q[STAGES-1];

endmodule

//--- src/xgphy_tx_reset_seq.sv
// Transmit reset sequencer: step counter, step strobe, stage register, output decode
`timescale 1ns/1ps

module xgphy_tx_reset_seq #(
	parameter int SEQ_CNT_W = xgphy_cfg_pkg::SEQ_CNT_W_DEF
) (
	// Transceiver clock
	input  logic i_wb_clk,
	// Primary reset, asynchronous, active high
	input  logic pll_reset,
	// Synchronized transceiver reset, already in i_wb_clk domain
	input  logic i_gtx_reset,
	// Whole-transceiver transmit reset
	output logic o_gtx_tx_reset,
	// Transmit PMA reset
	output logic o_tx_pma_reset,
	// Transmit PCS out of reset
	output logic o_tx_user_rdy
);

	import xgphy_rst_pkg::*;

	// Step counter and its strobe
	logic [SEQ_CNT_W-1:0] cnt_q;
	logic                 stb_q;
	logic                 cnt_hold;

	// Current stage
	tx_rst_stage_t stage_q;

	//////////////////////////////
	// Step counter
	//////////////////////////////

	// Counter parks at all ones
	// while the transceiver is held or the sequence is finished
	assign cnt_hold = i_gtx_reset || (stage_q == TX_RST_DONE);

	// Free running down-counter
	// Strobe is one cycle, registered off the zero count,
	// so it lands 2**SEQ_CNT_W cycles after release
	// and repeats every 2**SEQ_CNT_W cycles after that
	always_ff @(posedge i_wb_clk or posedge pll_reset)
	begin
		if (pll_reset)
		begin
			cnt_q <= '1;
			stb_q <= 1'b0;
		end
		else if (cnt_hold)
		begin
			cnt_q <= '1;
			stb_q <= 1'b0;
		end
		else
		begin
			// Wraps back to all ones from zero
			cnt_q <= cnt_q - 1'b1;
			stb_q <= (cnt_q == '0);
		end
	end

	//////////////////////////////
	// Stage register
	//////////////////////////////

	// One stage per strobe
	// Transceiver reset pulls back to the start at any time
	always_ff @(posedge i_wb_clk or posedge pll_reset)
	begin
		if (pll_reset)
		begin
			stage_q <= TX_RST_GTX;
		end
		else if (i_gtx_reset)
		begin
			stage_q <= TX_RST_GTX;
		end
		else if (stb_q)
		begin
			stage_q <= next_stage(stage_q);
		end
	end

	//////////////////////////////
	// Output decode
	//////////////////////////////

	// Released in order: gtx, then PMA, then PCS
	assign o_gtx_tx_reset = (stage_q == TX_RST_GTX);
	// PMA stays in reset one step longer than gtx
	assign o_tx_pma_reset = (stage_q == TX_RST_GTX) || (stage_q == TX_RST_PMA);
	// PCS release shows outward as user ready
	assign o_tx_user_rdy  = (stage_q == TX_RST_DONE);

endmodule

//--- src/xgphy_lane.sv
// Single lane: transmit reset sequencer, PHY fault synchronizer, lock status
`timescale 1ns/1ps

module xgphy_lane #(
	parameter int SEQ_CNT_W   = xgphy_cfg_pkg::SEQ_CNT_W_DEF,
	parameter int SYNC_STAGES = xgphy_cfg_pkg::SYNC_STAGES_DEF
) (
	// Transceiver clock and reset
	input  logic i_wb_clk,
	input  logic pll_reset,
	input  logic i_gtx_reset,
	// Recovered receive clock and receiver status
	input  logic i_rx_clk,
	input  logic i_rx_cdr_lock,
	input  logic i_rx_reset_done,
	// Transmit reset stages
	output logic o_gtx_tx_reset,
	output logic o_tx_pma_reset,
	output logic o_tx_user_rdy,
	// Status
	output logic o_phy_fault,
	output logic o_lock_status
);

	// Fault source, asynchronous to i_rx_clk
	logic fault_src;

	// Transmit reset sequence
	xgphy_tx_reset_seq #(
		.SEQ_CNT_W(SEQ_CNT_W)
	) u_tx_seq (
		.i_wb_clk       (i_wb_clk),
		.pll_reset      (pll_reset),
		.i_gtx_reset    (i_gtx_reset),
		.o_gtx_tx_reset (o_gtx_tx_reset),
		.o_tx_pma_reset (o_tx_pma_reset),
		.o_tx_user_rdy  (o_tx_user_rdy)
	);

	//////////////////////////////
	// PHY fault
	//////////////////////////////

	// Fault while the transceiver is held or CDR has no lock
	assign fault_src = i_gtx_reset || !i_rx_cdr_lock;

	// Set at once, cleared in the recovered clock domain
	xgphy_reset_sync #(
		.STAGES(SYNC_STAGES)
	) u_fault_sync (
		.i_clk  (i_rx_clk),
		.i_arst (fault_src),
		.o_rst  (o_phy_fault)
	);

	// Lane is locked once CDR has lock and receive reset is done
	assign o_lock_status = i_rx_cdr_lock && i_rx_reset_done;

endmodule

//--- src/xgphy_rst_top.sv
// Top level: transceiver reset synchronizer, lane array, lock status vector
`timescale 1ns/1ps

module xgphy_rst_top #(
	parameter int NDEV        = xgphy_cfg_pkg::NDEV_DEF,
	parameter int SEQ_CNT_W   = xgphy_cfg_pkg::SEQ_CNT_W_DEF,
	parameter int SYNC_STAGES = xgphy_cfg_pkg::SYNC_STAGES_DEF
) (
	// Transceiver clock and primary reset
	input  logic            i_wb_clk,
	input  logic            pll_reset,
	// Shared PLL lock
	input  logic            i_pll_lock,
	// Per-lane receiver inputs
	input  logic [NDEV-1:0] i_rx_clk,
	input  logic [NDEV-1:0] i_rx_cdr_lock,
	input  logic [NDEV-1:0] i_rx_reset_done,
	// Per-lane transmit reset stages
	output logic [NDEV-1:0] o_gtx_tx_reset,
	output logic [NDEV-1:0] o_tx_pma_reset,
	output logic [NDEV-1:0] o_tx_user_rdy,
	// Per-lane fault flags
	output logic [NDEV-1:0] o_phy_fault,
	// One bit per lane, PLL lock on top
	output logic [NDEV:0]   o_lock_status
);

	// Raw and synchronized transceiver reset
	logic gtx_arst;
	logic gtx_reset;

	//////////////////////////////
	// Transceiver reset
	//////////////////////////////

	// Held on primary reset or while the PLL is unlocked
	assign gtx_arst = pll_reset || !i_pll_lock;

	// Release lines up with i_wb_clk
	xgphy_reset_sync #(
		.STAGES(SYNC_STAGES)
	) u_gtx_sync (
		.i_clk  (i_wb_clk),
		.i_arst (gtx_arst),
		.o_rst  (gtx_reset)
	);

	//////////////////////////////
	// Lanes
	//////////////////////////////

	for (genvar gk = 0; gk < NDEV; gk++)
	begin : gen_lane
		xgphy_lane #(
			.SEQ_CNT_W   (SEQ_CNT_W),
			.SYNC_STAGES (SYNC_STAGES)
		) u_lane (
			.i_wb_clk        (i_wb_clk),
			.pll_reset       (pll_reset),
			.i_gtx_reset     (gtx_reset),
			.i_rx_clk        (i_rx_clk[gk]),
			.i_rx_cdr_lock   (i_rx_cdr_lock[gk]),
			.i_rx_reset_done (i_rx_reset_done[gk]),
			.o_gtx_tx_reset  (o_gtx_tx_reset[gk]),
			.o_tx_pma_reset  (o_tx_pma_reset[gk]),
			.o_tx_user_rdy   (o_tx_user_rdy[gk]),
			.o_phy_fault     (o_phy_fault[gk]),
			.o_lock_status   (o_lock_status[gk])
		);
	end

	// PLL lock as the final status bit
	assign o_lock_status[NDEV] = i_pll_lock;

endmodule

//--- tb/xgphy_lane_sva.sv
// Lane assertion module on reset stage order and fault, plus its bind to every lane
`timescale 1ns/1ps

module xgphy_lane_sva (
	input logic i_wb_clk,
	input logic pll_reset,
	input logic i_rx_clk,
	input logic i_rx_cdr_lock,
	input logic o_gtx_tx_reset,
	input logic o_tx_pma_reset,
	input logic o_tx_user_rdy,
	input logic o_phy_fault
);

	import xgphy_rst_pkg::*;

	// Stage as seen from the lane outputs
	tx_rst_stage_t stage_seen;

	// Assertion failures in this lane so far
	int fail_count = 0;

	always_comb
	begin
		if (o_gtx_tx_reset)
			stage_seen = TX_RST_GTX;
		else if (o_tx_pma_reset)
			stage_seen = TX_RST_PMA;
		else if (o_tx_user_rdy)
			stage_seen = TX_RST_DONE;
		else
			stage_seen = TX_RST_PCS;
	end

	//////////////////////////////
	// Transmit stage order
	//////////////////////////////

	// PCS only runs with both earlier stages released
	rdy_needs_release: assert property (@(posedge i_wb_clk) disable iff (pll_reset)
		o_tx_user_rdy |-> (!o_gtx_tx_reset && !o_tx_pma_reset))
		else
		begin
			$error("user ready with a transmit reset still high");
			fail_count++;
		end

	// PMA never released ahead of gtx
	gtx_implies_pma: assert property (@(posedge i_wb_clk) disable iff (pll_reset)
		o_gtx_tx_reset |-> o_tx_pma_reset)
		else
		begin
			$error("gtx reset high while PMA reset is low");
			fail_count++;
		end

	// No stage skipped on the way out of full reset
	gtx_then_pma: assert property (@(posedge i_wb_clk) disable iff (pll_reset)
		(stage_seen == TX_RST_GTX) |=> (stage_seen inside {TX_RST_GTX, TX_RST_PMA}))
		else
		begin
			$error("stage jumped past PMA out of full reset");
			fail_count++;
		end

	//////////////////////////////
	// Fault
	//////////////////////////////

	// Lost CDR lock shows as a fault by the next recovered edge
	cdr_loss_faults: assert property (@(posedge i_rx_clk)
		!i_rx_cdr_lock |=> o_phy_fault)
		else
		begin
			$error("no phy fault after CDR lock loss");
			fail_count++;
		end

endmodule

bind xgphy_lane xgphy_lane_sva u_lane_sva (
	.i_wb_clk       (i_wb_clk),
	.pll_reset      (pll_reset),
	.i_rx_clk       (i_rx_clk),
	.i_rx_cdr_lock  (i_rx_cdr_lock),
	.o_gtx_tx_reset (o_gtx_tx_reset),
	.o_tx_pma_reset (o_tx_pma_reset),
	.o_tx_user_rdy  (o_tx_user_rdy),
	.o_phy_fault    (o_phy_fault)
);

//--- tb/tb_xgphy_rst.sv
// Testbench for the reset controller: clocks, stimulus, reference functions, checker
`timescale 1ns/1ps

module tb_xgphy_rst;

	localparam int NDEV        = 2;
	localparam int SEQ_CNT_W   = 4;
	localparam int SYNC_STAGES = 3;
	// Cycles per reset step
	localparam int STEP        = 1 << SEQ_CNT_W;
	// Check kinds
	localparam int KIND_STAGE  = 0;
	localparam int KIND_LOCK   = 1;
	localparam int KIND_FAULT  = 2;

	logic            i_wb_clk;
	logic            pll_reset;
	logic            i_pll_lock;
	logic [NDEV-1:0] i_rx_clk;
	logic [NDEV-1:0] i_rx_cdr_lock;
	logic [NDEV-1:0] i_rx_reset_done;
	logic [NDEV-1:0] o_gtx_tx_reset;
	logic [NDEV-1:0] o_tx_pma_reset;
	logic [NDEV-1:0] o_tx_user_rdy;
	logic [NDEV-1:0] o_phy_fault;
	logic [NDEV:0]   o_lock_status;

	// Expectations handed to the checker
	event            do_check;
	int              check_kind;
	int              exp_stage = 0;
	logic [NDEV:0]   exp_lock;
	logic [NDEV-1:0] exp_fault;

	// Counters and random state
	int              errors = 0;
	int              checks = 0;
	int              tests_run = 0;
	int              tests_failed = 0;
	int              test_errors;
	string           test_name;
	logic [31:0]     rng_state = 32'd57;

	xgphy_rst_top #(
		.NDEV        (NDEV),
		.SEQ_CNT_W   (SEQ_CNT_W),
		.SYNC_STAGES (SYNC_STAGES)
	) dut_i (.*);

	// 40 ns transceiver clock, 32 and 48 ns recovered clocks
	always #20 i_wb_clk = ~i_wb_clk;
	always #16 i_rx_clk[0] = ~i_rx_clk[0];
	always #24 i_rx_clk[1] = ~i_rx_clk[1];

	//////////////////////////////
	// Reference and helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// {gtx reset, PMA reset, user ready} for stage 0..3
	function automatic logic [2:0] stage_reference(input int stage);
		logic [2:0] res;
		case (stage)
			0:       res = 3'b110;
			1:       res = 3'b010;
			2:       res = 3'b000;
			default: res = 3'b001;
		endcase
		return res;
	endfunction

	// Lane bit is CDR lock and reset done, PLL lock on top
	function automatic logic [NDEV:0] lock_reference(input logic [NDEV-1:0] cdr,
		input logic [NDEV-1:0] done, input logic pll);
		logic [NDEV:0] res;
		for (int k = 0; k < NDEV; k++)
			res[k] = cdr[k] & done[k];
		res[NDEV] = pll;
		return res;
	endfunction

	// Lands 2 ns past the rising edge
	task automatic wait_cycles(input int n);
		repeat (n)
		begin
			@(posedge i_wb_clk);
			#2;
		end
	endtask

	task automatic request_check(input int kind);
		check_kind = kind;
		#1;
		-> do_check;
		#1;
	endtask

	task automatic report_mismatch(input string name, input logic [NDEV:0] got,
		input logic [NDEV:0] exp);
		errors++;
		$display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == test_errors)
			$display("test %0d %s: ok", tests_run, test_name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, test_name, errors - test_errors);
		end
	endtask

	// All lanes showing the outputs of one stage
	task automatic wait_for_stage(input int stage, input int limit, output int cycles);
		logic [2:0] exp_out;
		bit         reached;
		exp_out = stage_reference(stage);
		cycles = 0;
		reached = 0;
		while (!reached && cycles < limit)
		begin
			wait_cycles(1);
			cycles++;
			reached = (o_gtx_tx_reset == {NDEV{exp_out[2]}}) &&
				(o_tx_pma_reset == {NDEV{exp_out[1]}}) && (o_tx_user_rdy == {NDEV{exp_out[0]}});
		end
		if (!reached)
		begin
			errors++;
			$display("timeout at %0t ns: lanes never reached stage %0d", $time, stage);
		end
	endtask

	// Lock the PLL and follow gtx, PMA and PCS release
	task automatic run_release_sequence();
		int cycles;
		wait_cycles(1);
		i_pll_lock = 1'b1;
		// Synchronizer delay plus one full step
		wait_for_stage(1, SYNC_STAGES + STEP + 2, cycles);
		exp_stage = 1;
		request_check(KIND_STAGE);
		for (int s = 2; s <= 3; s++)
		begin
			wait_for_stage(s, 2 * STEP, cycles);
			assert (cycles == STEP)
			else
			begin
				errors++;
				$display("mismatch at %0t ns: release spacing got %0d expected %0d",
					$time, cycles, STEP);
			end
			exp_stage = s;
			request_check(KIND_STAGE);
		end
	endtask

	// Raise one lane's CDR lock, count recovered edges until the fault clears
	task automatic check_fault_clear(input int lane);
		int edges;
		wait_cycles(1);
		i_rx_cdr_lock[lane] = 1'b1;
		edges = 0;
		while (o_phy_fault[lane] && edges < 8)
		begin
			if (lane == 0)
				@(posedge i_rx_clk[0]);
			else
				@(posedge i_rx_clk[1]);
			#1;
			edges++;
		end
		if (o_phy_fault[lane])
		begin
			errors++;
			$display("timeout at %0t ns: fault on lane %0d never cleared", $time, lane);
		end
		else
			assert (edges >= SYNC_STAGES && edges <= SYNC_STAGES + 1)
			else
			begin
				errors++;
				$display("mismatch at %0t ns: fault clear edges got %0d expected %0d",
					$time, edges, SYNC_STAGES);
			end
	endtask

	//////////////////////////////
	// Checker
	//////////////////////////////

	always @(do_check)
	begin
		logic [2:0] exp_out;
		checks++;
		exp_out = stage_reference(exp_stage);
		case (check_kind)
			KIND_STAGE:
			begin
				assert (o_gtx_tx_reset === {NDEV{exp_out[2]}})
				else
					report_mismatch("o_gtx_tx_reset", {1'b0, o_gtx_tx_reset},
						{1'b0, {NDEV{exp_out[2]}}});
				assert (o_tx_pma_reset === {NDEV{exp_out[1]}})
				else
					report_mismatch("o_tx_pma_reset", {1'b0, o_tx_pma_reset},
						{1'b0, {NDEV{exp_out[1]}}});
				assert (o_tx_user_rdy === {NDEV{exp_out[0]}})
				else
					report_mismatch("o_tx_user_rdy", {1'b0, o_tx_user_rdy},
						{1'b0, {NDEV{exp_out[0]}}});
			end
			KIND_LOCK:
				assert (o_lock_status === exp_lock)
				else
					report_mismatch("o_lock_status", o_lock_status, exp_lock);
			default:
				assert (o_phy_fault === exp_fault)
				else
					report_mismatch("o_phy_fault", {1'b0, o_phy_fault}, {1'b0, exp_fault});
		endcase
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial
	begin
		int hold;
		int sva_fails;
		i_wb_clk = 1'b0;
		i_rx_clk = '0;
		pll_reset = 1'b1;
		i_pll_lock = 1'b0;
		i_rx_cdr_lock = '0;
		i_rx_reset_done = '0;

		// Held through reset and while unlocked
		start_test("held in reset");
		wait_cycles(4);
		exp_stage = 0;
		request_check(KIND_STAGE);
		exp_fault = '1;
		request_check(KIND_FAULT);
		wait_cycles(4);
		pll_reset = 1'b0;
		wait_cycles(SYNC_STAGES + STEP + 4);
		request_check(KIND_STAGE);
		request_check(KIND_FAULT);
		finish_test();

		start_test("release order");
		run_release_sequence();
		finish_test();

		// Lock loss drops all lanes, faults follow via gtx reset
		start_test("lock loss and recovery");
		i_rx_cdr_lock = '1;
		wait_cycles(8);
		exp_fault = '0;
		request_check(KIND_FAULT);
		wait_cycles(1);
		i_pll_lock = 1'b0;
		exp_fault = '1;
		request_check(KIND_FAULT);
		wait_for_stage(0, SYNC_STAGES + 2, hold);
		exp_stage = 0;
		request_check(KIND_STAGE);
		run_release_sequence();
		finish_test();

		// Each lane faults and clears on its own
		start_test("phy fault per lane");
		wait_cycles(1);
		i_rx_cdr_lock = '0;
		exp_fault = '1;
		request_check(KIND_FAULT);
		check_fault_clear(0);
		exp_fault = 2'b10;
		request_check(KIND_FAULT);
		check_fault_clear(1);
		exp_fault = 2'b00;
		request_check(KIND_FAULT);
		wait_cycles(1);
		i_rx_cdr_lock[1] = 1'b0;
		exp_fault = 2'b10;
		request_check(KIND_FAULT);
		wait_cycles(1);
		i_rx_cdr_lock[0] = 1'b0;
		exp_fault = 2'b11;
		request_check(KIND_FAULT);
		finish_test();

		// Random lock and reset done patterns
		start_test("lock status");
		for (int n = 0; n < 20; n++)
		begin
			wait_cycles(1);
			rng_state = xorshift32(rng_state);
			i_rx_cdr_lock = rng_state[1:0];
			i_rx_reset_done = rng_state[3:2];
			i_pll_lock = rng_state[4];
			hold = 1 + rng_state[9:8];
			exp_lock = lock_reference(i_rx_cdr_lock, i_rx_reset_done, i_pll_lock);
			request_check(KIND_LOCK);
			wait_cycles(hold);
		end
		finish_test();

		// Bound lane assertions count toward the result
		sva_fails = dut_i.gen_lane[0].u_lane.u_lane_sva.fail_count +
			dut_i.gen_lane[1].u_lane.u_lane_sva.fail_count;
		if (sva_fails > 0)
			$display("lane assertions failed %0d times", sva_fails);
		errors += sva_fails;

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- xgphy_rst.f
src/xgphy_cfg_pkg.sv
src/xgphy_rst_pkg.sv
src/xgphy_reset_sync.sv
src/xgphy_tx_reset_seq.sv
src/xgphy_lane.sv
src/xgphy_rst_top.sv
tb/xgphy_lane_sva.sv
tb/tb_xgphy_rst.sv
